//--- stack_core_config.svh
// ------------------------------------------------
// Widths and stack depths of the core
// The instruction word is OPCODE_W + OPERAND_W bits wide
// Instruction and data addresses come from the operand field
// ------------------------------------------------

`ifndef STACK_CORE_CONFIG_SVH
`define STACK_CORE_CONFIG_SVH

// Instruction word fields
`define OPCODE_W 7
`define OPERAND_W 9

// Memory address widths
`define IADDR_W 9
`define DADDR_W 9

// Datapath and output port
`define DATA_W 16
`define IOOUT_W 2

// Stack depths in entries
`define DSTACK_DEPTH 8
`define RSTACK_DEPTH 8

`endif

//--- stack_core_pkg.sv
// ------------------------------------------------
// Shared types of the stack core
// Opcode codes that are not listed decode as NOP
// ------------------------------------------------

`default_nettype none

`include "stack_core_config.svh"

package stack_core_pkg;

	// Instruction word, opcode in the upper bits
	typedef logic [`OPCODE_W+`OPERAND_W-1:0] instr_t;
	typedef logic [`OPERAND_W-1:0]           operand_t;

	typedef enum logic [`OPCODE_W-1:0] {
		OP_NOP   = 0,
		OP_LOD   = 1,
		OP_SET   = 2,
		OP_PSH   = 3,
		OP_POP   = 4,
		OP_ADD   = 5,
		OP_S_ADD = 6,
		OP_AND   = 7,
		OP_S_AND = 8,
		OP_XOR   = 9,
		OP_S_XOR = 10,
		OP_LES   = 11,
		OP_S_LES = 12,
		OP_OUT   = 13,
		OP_JMP   = 15,
		OP_JIZ   = 16,
		OP_CAL   = 17,
		OP_RET   = 18
	} opcode_t;

	// Addresses and data
	typedef logic [`IADDR_W-1:0]       iaddr_t;
	typedef logic [`DADDR_W-1:0]       daddr_t;
	typedef logic signed [`DATA_W-1:0] data_t;
	typedef logic [`IOOUT_W-1:0]       ioaddr_t;

	// PASS keeps the accumulator
	typedef enum logic [2:0] {
		ALU_PASS,
		ALU_LOAD,
		ALU_ADD,
		ALU_AND,
		ALU_XOR,
		ALU_LES
	} alu_op_t;

endpackage

`default_nettype wire

//--- lifo_stack.sv
// ------------------------------------------------
// LIFO stack with no full or empty outputs
// The user must not push when full or pop when empty
// Push and pop in the same cycle are not supported
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module lifo_stack #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 8
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     push,
	input  logic     pop,
	input  payload_t din,
	output payload_t top
);

	localparam int PTR_W = $clog2(DEPTH + 1);
	localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	// Pointer counts the entries held
	logic [PTR_W-1:0] ptr;
	logic [PTR_W-1:0] ptr_dec;
	payload_t         mem [DEPTH];

	assign ptr_dec = ptr - 1'b1;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			ptr <= '0;
		else if (push)
			ptr <= ptr + 1'b1;
		else if (pop)
			ptr <= ptr_dec;
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[ptr[IDX_W-1:0]] <= din;
	end

	// Most recent entry, meaningless while empty
	assign top = mem[ptr_dec[IDX_W-1:0]];

	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		push |-> (int'(ptr) < DEPTH));

	a_no_underflow: assert property (@(posedge clk) disable iff (rst)
		pop |-> (ptr != '0));

	a_no_push_pop: assert property (@(posedge clk) disable iff (rst)
		!(push && pop));

endmodule

`default_nettype wire

//--- alu.sv
// ------------------------------------------------
// Integer ALU, purely combinational
// Results wrap at DATA_W bits, LES is a signed compare
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module alu
	import stack_core_pkg::*;
(
	input  alu_op_t op,
	input  data_t   in1,
	input  data_t   in2,
	output data_t   result
);

	// in2 is always the accumulator
	always_comb begin
		case (op)
			ALU_PASS: result = in2;
			ALU_LOAD: result = in1;
			ALU_ADD:  result = in1 + in2;
			ALU_AND:  result = in1 & in2;
			ALU_XOR:  result = in1 ^ in2;
			ALU_LES:  result = (in1 < in2) ? data_t'(1) : data_t'(0);
			default:  result = in2;
		endcase
	end

endmodule

`default_nettype wire

//--- instr_fetch.sv
// ------------------------------------------------
// PC, jump prefetch and return-address stack
// Instruction memory must have one cycle of read latency
// Jumps take effect in decode so no bubble is inserted
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "stack_core_config.svh"

module instr_fetch
	import stack_core_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  instr_t   instr,
	input  logic     acc_lsb,
	output iaddr_t   instr_addr,
	output opcode_t  opcode,
	output operand_t operand
);

	iaddr_t pc;
	iaddr_t ret_top;
	logic   is_jmp;
	logic   is_jiz;
	logic   is_cal;
	logic   is_ret;
	logic   take_operand;

	// Instruction fields
	assign opcode  = opcode_t'(instr[`OPCODE_W+`OPERAND_W-1:`OPERAND_W]);
	assign operand = instr[`OPERAND_W-1:0];

	// ------------------------------------------------
	// Control-flow decode

	assign is_jmp = (opcode == OP_JMP);
	assign is_jiz = (opcode == OP_JIZ);
	assign is_cal = (opcode == OP_CAL);
	assign is_ret = (opcode == OP_RET);

	// JIZ tests the value the accumulator is about to take
	assign take_operand = is_jmp | (is_jiz & ~acc_lsb) | is_cal;

	always_comb begin
		if (rst)
			instr_addr = '0;
		else if (take_operand)
			instr_addr = iaddr_t'(operand);
		else if (is_ret)
			instr_addr = ret_top;
		else
			instr_addr = pc;
	end

	// ------------------------------------------------
	// Program counter

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			pc <= '0;
		else
			pc <= instr_addr + 1'b1;
	end

	// PC already points past the CAL here
	lifo_stack #(
		.payload_t(iaddr_t),
		.DEPTH    (`RSTACK_DEPTH)
	) ret_stack_i (
		.clk (clk),
		.rst (rst),
		.push(is_cal),
		.pop (is_ret),
		.din (pc),
		.top (ret_top)
	);

	a_reset_fetch: assert property (@(posedge clk)
		rst |-> (pc == '0 && instr_addr == '0));

endmodule

`default_nettype wire

//--- instr_dec.sv
// ------------------------------------------------
// Data-path decoder
// Stack strobes act in decode, execute controls one cycle later
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module instr_dec
	import stack_core_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  opcode_t  opcode,
	input  operand_t operand,
	output logic     dpush,
	output logic     dpop,
	output alu_op_t  alu_op,
	output logic     stack_sel,
	output logic     mem_wr,
	output logic     out_en,
	output daddr_t   wr_addr
);

	alu_op_t op_d;
	logic    wr_d;
	logic    out_d;

	// Stack strobes
	assign dpush = (opcode == OP_PSH);

	always_comb begin
		case (opcode)
			OP_POP, OP_S_ADD, OP_S_AND, OP_S_XOR, OP_S_LES: dpop = 1'b1;
			default: dpop = 1'b0;
		endcase
	end

	// S_ ops share the ALU op of the memory form
	always_comb begin
		op_d  = ALU_PASS;
		wr_d  = 1'b0;
		out_d = 1'b0;
		case (opcode)
			OP_LOD, OP_POP:   op_d = ALU_LOAD;
			OP_ADD, OP_S_ADD: op_d = ALU_ADD;
			OP_AND, OP_S_AND: op_d = ALU_AND;
			OP_XOR, OP_S_XOR: op_d = ALU_XOR;
			OP_LES, OP_S_LES: op_d = ALU_LES;
			OP_SET:           wr_d = 1'b1;
			OP_OUT:           out_d = 1'b1;
			default:          op_d = ALU_PASS;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			alu_op    <= ALU_PASS;
			stack_sel <= 1'b0;
			mem_wr    <= 1'b0;
			out_en    <= 1'b0;
		end else begin
			alu_op    <= op_d;
			stack_sel <= dpop;
			mem_wr    <= wr_d;
			out_en    <= out_d;
		end
	end

	// Write address and output port address
	always_ff @(posedge clk) begin
		wr_addr <= daddr_t'(operand);
	end

	a_wr_out_excl: assert property (@(posedge clk) disable iff (rst)
		!(mem_wr && out_en));

endmodule

`default_nettype wire

//--- exec_stage.sv
// ------------------------------------------------
// Execute stage with operand select and accumulator
// Popped stack data is held for one cycle only
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module exec_stage
	import stack_core_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    dpop,
	input  alu_op_t alu_op,
	input  logic    stack_sel,
	input  data_t   stack_top,
	input  data_t   mem_data_rd,
	output data_t   acc_next
);

	data_t top_q;
	data_t in1;
	data_t acc;

	// Stack top as it was when the pop left decode
	always_ff @(posedge clk) begin
		if (dpop)
			top_q <= stack_top;
	end

	assign in1 = stack_sel ? top_q : mem_data_rd;

	alu alu_i (
		.op    (alu_op),
		.in1   (in1),
		.in2   (acc),
		.result(acc_next)
	);

	// Accumulator
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			acc <= '0;
		else
			acc <= acc_next;
	end

endmodule

`default_nettype wire

//--- stack_core.sv
// ------------------------------------------------
// Stack core top level
// Both memories are synchronous with one cycle of read latency
// Data memory must be write-first on an address collision
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "stack_core_config.svh"

module stack_core
	import stack_core_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  instr_t  instr,
	output iaddr_t  instr_addr,
	output logic    mem_wr,
	output daddr_t  mem_addr_rd,
	output daddr_t  mem_addr_wr,
	input  data_t   mem_data_rd,
	output data_t   mem_data_wr,
	output logic    out_en,
	output ioaddr_t addr_out
);

	opcode_t  opcode;
	operand_t operand;
	logic     dpush;
	logic     dpop;
	alu_op_t  alu_op;
	logic     stack_sel;
	data_t    stack_top;
	data_t    acc_next;

	// ------------------------------------------------
	// Fetch and decode

	instr_fetch instr_fetch_i (
		.clk       (clk),
		.rst       (rst),
		.instr     (instr),
		.acc_lsb   (acc_next[0]),
		.instr_addr(instr_addr),
		.opcode    (opcode),
		.operand   (operand)
	);

	instr_dec instr_dec_i (
		.clk      (clk),
		.rst      (rst),
		.opcode   (opcode),
		.operand  (operand),
		.dpush    (dpush),
		.dpop     (dpop),
		.alu_op   (alu_op),
		.stack_sel(stack_sel),
		.mem_wr   (mem_wr),
		.out_en   (out_en),
		.wr_addr  (mem_addr_wr)
	);

	// ------------------------------------------------
	// Data stack and execute

	lifo_stack #(
		.payload_t(data_t),
		.DEPTH    (`DSTACK_DEPTH)
	) data_stack_i (
		.clk (clk),
		.rst (rst),
		.push(dpush),
		.pop (dpop),
		.din (acc_next),
		.top (stack_top)
	);

	exec_stage exec_stage_i (
		.clk        (clk),
		.rst        (rst),
		.dpop       (dpop),
		.alu_op     (alu_op),
		.stack_sel  (stack_sel),
		.stack_top  (stack_top),
		.mem_data_rd(mem_data_rd),
		.acc_next   (acc_next)
	);

	// Memory and port pins
	assign mem_addr_rd = daddr_t'(operand);
	assign mem_data_wr = acc_next;
	assign addr_out    = mem_addr_wr[`IOOUT_W-1:0];

endmodule

`default_nettype wire

//--- tb_clock.sv
// ------------------------------------------------
// Free-running testbench clock, starts low
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 100
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- tb_stack_core.sv
// ------------------------------------------------
// Random programs run on the core and on a model
// Address 0 always holds a NOP, each program ends in a self-JMP
// Data addresses stay in 0..15 so writes and reads collide often
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "stack_core_config.svh"

module tb_stack_core
	import stack_core_pkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int MEM_WORDS  = 1 << `IADDR_W;
	localparam int NUM_PROGS  = 32;
	localparam int MAX_STEPS  = 300;
	// Reset, program run and slack for every program
	localparam int WATCHDOG_CYCLES = NUM_PROGS * (2 * MAX_STEPS + 24) + 100;

	logic    clk;
	logic    rst;
	instr_t  instr;
	iaddr_t  instr_addr;
	logic    mem_wr;
	daddr_t  mem_addr_rd;
	daddr_t  mem_addr_wr;
	data_t   mem_data_rd;
	data_t   mem_data_wr;
	logic    out_en;
	ioaddr_t addr_out;

	instr_t imem  [MEM_WORDS];
	data_t  dmem  [MEM_WORDS];
	data_t  m_mem [MEM_WORDS];
	data_t  m_dstack [$];
	iaddr_t m_rstack [$];

	// Expected events, kind 1 is an output strobe
	bit     exp_kind [$];
	daddr_t exp_addr [$];
	data_t  exp_data [$];
	int     plen;

	tb_clock #(.PERIOD(CLK_PERIOD)) clock_i (.clk(clk));

	stack_core dut_i (
		.clk        (clk),
		.rst        (rst),
		.instr      (instr),
		.instr_addr (instr_addr),
		.mem_wr     (mem_wr),
		.mem_addr_rd(mem_addr_rd),
		.mem_addr_wr(mem_addr_wr),
		.mem_data_rd(mem_data_rd),
		.mem_data_wr(mem_data_wr),
		.out_en     (out_en),
		.addr_out   (addr_out)
	);

	// ------------------------------------------------
	// Memories, synchronous and write-first

	always @(posedge clk) begin
		instr <= imem[instr_addr];
		if (mem_wr)
			dmem[mem_addr_wr] <= mem_data_wr;
		if (mem_wr && mem_addr_wr == mem_addr_rd)
			mem_data_rd <= mem_data_wr;
		else
			mem_data_rd <= dmem[mem_addr_rd];
	end

	task halt_failed();
		$display("Some tests failed");
		$fatal(1);
	endtask

	task add_event(input bit kind, input daddr_t addr, input data_t data);
		exp_kind.push_back(kind);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task drop_event();
		exp_kind.delete(0);
		exp_addr.delete(0);
		exp_data.delete(0);
	endtask

	// ------------------------------------------------
	// Checkers

	task check_write(input daddr_t addr, input data_t data);
		if (exp_kind.size() == 0) begin
			$display("Memory write to address %h when no event was expected", addr);
			halt_failed();
		end else if (exp_kind[0]) begin
			$display("Memory write seen where an output strobe was expected");
			halt_failed();
		end else if (addr !== exp_addr[0]) begin
			$display("** Error: mem_addr_wr = %h, expected %h", addr, exp_addr[0]);
			halt_failed();
		end else if (data !== exp_data[0]) begin
			$display("** Error: mem_data_wr = %h, expected %h", data, exp_data[0]);
			halt_failed();
		end else begin
			drop_event();
		end
	endtask

	task check_out(input ioaddr_t port, input data_t data);
		if (exp_kind.size() == 0) begin
			$display("Output strobe on port %h when no event was expected", port);
			halt_failed();
		end else if (!exp_kind[0]) begin
			$display("Output strobe seen where a memory write was expected");
			halt_failed();
		end else if (port !== ioaddr_t'(exp_addr[0])) begin
			$display("** Error: addr_out = %h, expected %h", port, ioaddr_t'(exp_addr[0]));
			halt_failed();
		end else if (data !== exp_data[0]) begin
			$display("** Error: mem_data_wr = %h, expected %h", data, exp_data[0]);
			halt_failed();
		end else begin
			drop_event();
		end
	endtask

	// Mid-cycle sampling, outputs settled
	always @(negedge clk) begin
		if (!rst) begin
			if (mem_wr)
				check_write(mem_addr_wr, mem_data_wr);
			if (out_en)
				check_out(addr_out, mem_data_wr);
		end
	end

	// ------------------------------------------------
	// Program generator

	function automatic opcode_t pick_mem_op();
		case ($urandom_range(0, 6))
			0: return OP_LOD;
			1: return OP_SET;
			2: return OP_ADD;
			3: return OP_AND;
			4: return OP_XOR;
			5: return OP_LES;
			default: return OP_OUT;
		endcase
	endfunction

	function automatic opcode_t pop_kind(input int k);
		case (k)
			1: return OP_POP;
			2: return OP_S_ADD;
			3: return OP_S_AND;
			4: return OP_S_XOR;
			default: return OP_S_LES;
		endcase
	endfunction

	// Subroutine k of a call program, six words each
	function automatic int sub_addr(input int n, input int k);
		return n + 2 + 6 * k;
	endfunction

	task emit(input opcode_t op, input int opd);
		imem[iaddr_t'(plen)] = {op, operand_t'(opd)};
		plen = plen + 1;
	endtask

	// Kinds: 0 straight line, 1 stack, 2 forward branches, 3 calls
	task gen_program(input int kind, input int n);
		int depth;
		int ncal;
		int a;
		int k;
		int i;
		plen  = 0;
		depth = 0;
		ncal  = 0;
		emit(OP_NOP, 0);
		for (i = 1; i <= n; i++) begin
			a = $urandom_range(0, 15);
			k = $urandom_range(0, 7);
			case (kind)
				0: begin
					if (k == 0 && i < n) begin
						emit(OP_SET, a);
						emit(OP_LOD, a);
						i++;
					end else begin
						emit(pick_mem_op(), a);
					end
				end
				1: begin
					if (depth == 0 && k >= 1 && k <= 5)
						k = 0;
					if (depth == `DSTACK_DEPTH && k == 0)
						k = 1;
					if (k == 0) begin
						emit(OP_PSH, a);
						depth++;
					end else if (k <= 5) begin
						emit(pop_kind(k), a);
						depth--;
					end else if (k == 6) begin
						emit(OP_SET, a);
					end else begin
						emit(pick_mem_op(), a);
					end
				end
				2: begin
					if (k < 3)
						emit((k == 0) ? OP_JMP : OP_JIZ, $urandom_range(i + 1, n + 1));
					else
						emit(pick_mem_op(), a);
				end
				default: begin
					if (k == 0 && ncal < 4) begin
						emit(OP_CAL, sub_addr(n, $urandom_range(0, 3)));
						ncal++;
					end else begin
						emit(pick_mem_op(), a);
					end
				end
			endcase
		end
		emit(OP_JMP, plen);
		// Subroutine k may call k+1, so nesting reaches 4 at most
		if (kind == 3) begin
			for (k = 0; k < 4; k++) begin
				for (i = 0; i < 4; i++) begin
					a = $urandom_range(0, 15);
					if ($urandom_range(0, 1) == 0)
						emit(OP_SET, a);
					else
						emit(pick_mem_op(), a);
				end
				if (k < 3 && $urandom_range(0, 1) == 1)
					emit(OP_CAL, sub_addr(n, k + 1));
				else
					emit(OP_NOP, 0);
				emit(OP_RET, 0);
			end
		end
	endtask

	// ------------------------------------------------
	// Instruction-level model

	task run_model(output int steps);
		iaddr_t   pc;
		iaddr_t   nxt;
		data_t    acc;
		data_t    a;
		data_t    t;
		instr_t   w;
		opcode_t  op;
		operand_t opd;
		bit       done;
		pc    = '0;
		acc   = '0;
		steps = 0;
		done  = 1'b0;
		m_dstack.delete();
		m_rstack.delete();
		while (!done) begin
			w   = imem[pc];
			op  = opcode_t'(w[`OPCODE_W+`OPERAND_W-1:`OPERAND_W]);
			opd = w[`OPERAND_W-1:0];
			if (op == OP_JMP && iaddr_t'(opd) == pc) begin
				done = 1'b1;
			end else if (steps == MAX_STEPS) begin
				$display("Model ran past %0d instructions without reaching the end", MAX_STEPS);
				halt_failed();
			end else begin
				steps++;
				nxt = pc + 1'b1;
				a   = m_mem[daddr_t'(opd)];
				case (op)
					OP_LOD: acc = a;
					OP_SET: begin
						m_mem[daddr_t'(opd)] = acc;
						add_event(1'b0, daddr_t'(opd), acc);
					end
					OP_PSH:   m_dstack.push_back(acc);
					OP_POP:   acc = m_dstack.pop_back();
					OP_ADD:   acc = a + acc;
					OP_AND:   acc = a & acc;
					OP_XOR:   acc = a ^ acc;
					OP_LES:   acc = (a < acc) ? data_t'(1) : data_t'(0);
					OP_S_ADD: acc = m_dstack.pop_back() + acc;
					OP_S_AND: acc = m_dstack.pop_back() & acc;
					OP_S_XOR: acc = m_dstack.pop_back() ^ acc;
					OP_S_LES: begin
						t   = m_dstack.pop_back();
						acc = (t < acc) ? data_t'(1) : data_t'(0);
					end
					OP_OUT: add_event(1'b1, daddr_t'(opd), acc);
					OP_JMP: nxt = iaddr_t'(opd);
					OP_JIZ: begin
						if (!acc[0])
							nxt = iaddr_t'(opd);
					end
					OP_CAL: begin
						m_rstack.push_back(pc + 1'b1);
						nxt = iaddr_t'(opd);
					end
					OP_RET: nxt = m_rstack.pop_back();
					default: ;
				endcase
				pc = nxt;
			end
		end
	endtask

	// ------------------------------------------------
	// Test sequence

	task run_program(input int kind, input int idx);
		int steps;
		int i;
		@(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		gen_program(kind, $urandom_range(8, 40));
		for (i = 0; i < MEM_WORDS; i++)
			m_mem[i] = dmem[i];
		run_model(steps);
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		repeat (2 * steps + 20) @(posedge clk);
		if (exp_kind.size() != 0) begin
			$display("Program %0d ended with %0d expected events never seen",
				idx, exp_kind.size());
			halt_failed();
		end
	endtask

	initial begin
		int i;
		rst         <= 1'b1;
		instr       <= '0;
		mem_data_rd <= '0;
		void'($urandom(32'h1c04));
		for (i = 0; i < MEM_WORDS; i++) begin
			dmem[i] <= data_t'($urandom);
			imem[i] = '0;
		end
		for (i = 0; i < NUM_PROGS; i++)
			run_program(i % 4, i);
		$display("All tests passed");
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout after %0d cycles", WATCHDOG_CYCLES);
		halt_failed();
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
stack_core_pkg.sv
lifo_stack.sv
alu.sv
instr_fetch.sv
instr_dec.sv
exec_stage.sv
stack_core.sv
tb_clock.sv
tb_stack_core.sv

//--- run.sh
#!/bin/sh
# Build and run the stack core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_stack_core \
	--Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
	exit 0
fi
exit 1
